/* verilog/link_pkg.sv */
`default_nettype none

// Serial link definitions shared by the receiver, transmitter and demo controller
package link_pkg;

   // Width of one stream word, one UART character
   parameter int DATA_WIDTH = 8;

   // Byte repeated on the transmitter in pattern mode
   parameter logic [DATA_WIDTH-1:0] PATTERN_BYTE = 8'hcd;

   // Demo mode as decoded from switch[1:0], 2'b11 also selects sink
   typedef enum logic [1:0] {
      MODE_LOOPBACK = 2'b00, // Received bytes go straight back out
      MODE_PATTERN  = 2'b01, // Fixed byte sent without pause
      MODE_SINK     = 2'b10  // Received bytes are absorbed
   } demo_mode_t;

   // Receiver frame state
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // Transmitter frame state
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

`default_nettype wire

/* verilog/display_pkg.sv */
`default_nettype none

// Seven-segment display definitions for the rate meter and the digit scanner
package display_pkg;

   // Digits on the board display
   parameter int NUM_DIGITS = 8;

   // Digit that carries the lit decimal point
   parameter int DP_DIGIT = 3;

   // Segment pattern, bit 6 is g and bit 0 is a, a low bit lights the segment
   typedef logic [6:0] seg_code_t;

   // Decimal digit to segment pattern
   parameter seg_code_t DIGIT_SEGMENTS [0:9] = '{
      7'h40, // 0
      7'h79, // 1
      7'h24, // 2
      7'h30, // 3
      7'h19, // 4
      7'h12, // 5
      7'h02, // 6
      7'h78, // 7
      7'h00, // 8
      7'h10  // 9
   };

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

// UART receiver, 8N1, with a one-byte holding register on a valid/ready stream
module uart_rx import link_pkg::*; #(
   parameter int CLKS_PER_BIT = 33
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rx,
   output logic [DATA_WIDTH-1:0] data,
   output logic                  valid,
   input  logic                  ready,
   output logic                  error
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam int BIT_W = $clog2(DATA_WIDTH);

   rx_state_t             state;
   logic                  rx_meta;            // First synchronizer stage
   logic                  rx_sync;            // Line level safe to use in this domain
   logic                  rx_last;            // Previous rx_sync, for the start edge
   logic [CNT_W-1:0]      cnt;                // Clocks within the current bit
   logic [BIT_W-1:0]      bit_cnt;
   logic [DATA_WIDTH-1:0] shift;
   logic                  bit_end;
   logic                  half_end;
   logic                  frame_done;
   logic                  full;
   logic                  load;

   assign bit_end    = (cnt == CNT_W'(CLKS_PER_BIT - 1));
   assign half_end   = (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
   assign frame_done = (state == RX_STOP) && bit_end; // Middle of the stop bit
   assign full       = valid && !ready;              // Byte still waiting after this edge
   assign load       = frame_done && rx_sync && !full;

   always_ff @(posedge clk) begin
      if (rst) begin
         rx_meta <= 1'b1; // Idle line level
         rx_sync <= 1'b1;
         rx_last <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_last <= rx_sync;
      end
   end

   // Frame FSM, sampling every bit in its middle
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               // Only a real falling edge starts a frame, so a line held low is ignored
               if (rx_last && !rx_sync) state <= RX_START;
            end
            RX_START: begin
               cnt <= cnt + 1'b1;
               if (half_end) begin
                  cnt     <= '0;
                  bit_cnt <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA; // Line back high means a glitch
               end
            end
            RX_DATA: begin
               cnt <= cnt + 1'b1;
               if (bit_end) begin
                  cnt     <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == BIT_W'(DATA_WIDTH - 1)) state <= RX_STOP;
               end
            end
            default: begin // RX_STOP
               cnt <= cnt + 1'b1;
               if (bit_end) state <= RX_IDLE;
            end
         endcase
      end
   end

   // LSB arrives first, so bits enter from the top
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_end) shift <= {rx_sync, shift[DATA_WIDTH-1:1]};
      if (load) data <= shift;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= 1'b0;
         error <= 1'b0;
      end else begin
         if (load) valid <= 1'b1;
         else if (ready) valid <= 1'b0;                // Emptied by the transfer
         error <= frame_done && (!rx_sync || full);    // Framing error or overrun
      end
   end

   // A byte on offer may not change or disappear before it is taken
   a_rx_hold: assert property (@(posedge clk) disable iff (rst)
      valid && !ready |=> valid && $stable(data));

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

// UART transmitter, 8N1, frames start only while the far side asserts cts
module uart_tx import link_pkg::*; #(
   parameter int CLKS_PER_BIT = 33
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [DATA_WIDTH-1:0] data,
   input  logic                  valid,
   input  logic                  cts,
   output logic                  ready,
   output logic                  tx
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam int BIT_W = $clog2(DATA_WIDTH);

   tx_state_t             state;
   logic                  cts_meta;
   logic                  cts_sync;
   logic [CNT_W-1:0]      cnt;
   logic [BIT_W-1:0]      bit_cnt;
   logic [DATA_WIDTH-1:0] shift;   // shift[0] is the next data bit on the line
   logic                  bit_end;

   assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));
   assign ready   = (state == TX_IDLE) && cts_sync; // Taking a byte commits to a frame

   always_ff @(posedge clk) begin
      if (rst) begin
         cts_meta <= 1'b0;
         cts_sync <= 1'b0;
      end else begin
         cts_meta <= cts;
         cts_sync <= cts_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
         tx      <= 1'b1;
      end else begin
         cnt <= bit_end ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt <= '0;
               if (valid && ready) begin
                  tx    <= 1'b0; // Start bit in the cycle after the transfer
                  state <= TX_START;
               end
            end
            TX_START: if (bit_end) begin
               tx      <= shift[0];
               bit_cnt <= '0;
               state   <= TX_DATA;
            end
            TX_DATA: if (bit_end) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == BIT_W'(DATA_WIDTH - 1)) begin
                  tx    <= 1'b1; // Stop bit
                  state <= TX_STOP;
               end else begin
                  tx <= shift[1];
               end
            end
            default: if (bit_end) state <= TX_IDLE; // TX_STOP, a started frame always ends
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == TX_IDLE && valid && ready) shift <= data;
      else if (state == TX_DATA && bit_end) shift <= shift >> 1;
   end

   // Line rests at mark level between frames
   a_tx_idle_high: assert property (@(posedge clk) disable iff (rst)
      state == TX_IDLE |-> tx);

endmodule

`default_nettype wire

/* verilog/demo_control.sv */
`timescale 1ns/1ps
`default_nettype none

// Stream routing by switch setting, plus the error LED and the rts output
module demo_control import link_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [2:0]            switch,
   input  logic [DATA_WIDTH-1:0] in_data,
   input  logic                  in_valid,
   output logic                  in_ready,
   output logic [DATA_WIDTH-1:0] out_data,
   output logic                  out_valid,
   input  logic                  out_ready,
   input  logic                  rx_error,
   output logic                  rts,
   output logic                  xfer_pulse,
   output logic                  redled
);

   demo_mode_t mode;
   logic       error_latched; // Sticky until reset

   always_comb begin
      if (switch[1]) mode = MODE_SINK;
      else if (switch[0]) mode = MODE_PATTERN;
      else mode = MODE_LOOPBACK;
   end

   always_comb begin
      case (mode)
         MODE_LOOPBACK: begin
            out_data  = in_data;   // Receiver feeds transmitter directly
            out_valid = in_valid;
            in_ready  = out_ready;
         end
         MODE_PATTERN: begin
            out_data  = PATTERN_BYTE;
            out_valid = 1'b1;      // Always something to send
            in_ready  = 1'b0;
         end
         default: begin
            out_data  = '0;
            out_valid = 1'b0;
            in_ready  = switch[2]; // Switch 2 opens the sink
         end
      endcase
   end

   // One count per cycle, even when both streams move together
   assign xfer_pulse = (in_valid && in_ready) || (out_valid && out_ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         error_latched <= 1'b0;
         redled        <= 1'b0;
         rts           <= 1'b0;
      end else begin
         error_latched <= error_latched | rx_error;
         if (error_latched) redled <= ~redled; // Toggles every clock once an error was seen
         rts <= in_ready;
      end
   end

endmodule

`default_nettype wire

/* verilog/rate_meter.sv */
`timescale 1ns/1ps
`default_nettype none

// Counts stream transfers per window as BCD and shows the last complete window
module rate_meter import display_pkg::*; #(
   parameter int WINDOW_CYCLES = 100_000_000
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       xfer_pulse,
   output logic [NUM_DIGITS-1:0][3:0] digit_values
);

   localparam int WIN_W = $clog2(WINDOW_CYCLES + 1);

   logic [WIN_W-1:0]            win_cnt;    // Position inside the current window
   logic                        window_end;
   logic [NUM_DIGITS-1:0][3:0]  count;      // Running BCD count, digit 0 is the ones
   logic [NUM_DIGITS-1:0][3:0]  count_inc;  // count plus one
   logic [NUM_DIGITS:0]         carry;      // carry[i] goes into digit i
   logic [NUM_DIGITS-1:0][3:0]  count_next;

   assign window_end = (win_cnt == WIN_W'(WINDOW_CYCLES - 1));

   // Ripple of decade counters, each wraps at nine into the next
   always_comb begin
      carry[0] = 1'b1;
      for (int i = 0; i < NUM_DIGITS; i++) begin
         if (carry[i] && count[i] == 4'd9) begin
            count_inc[i] = 4'd0;
            carry[i+1]   = 1'b1;
         end else if (carry[i]) begin
            count_inc[i] = count[i] + 4'd1;
            carry[i+1]   = 1'b0;
         end else begin
            count_inc[i] = count[i];
            carry[i+1]   = 1'b0;
         end
      end
   end

   // Carry out of the top digit means all nines, where the count stops
   assign count_next = (xfer_pulse && !carry[NUM_DIGITS]) ? count_inc : count;

   always_ff @(posedge clk) begin
      if (rst) begin
         win_cnt      <= '0;
         count        <= '0;
         digit_values <= '0;
      end else if (window_end) begin
         win_cnt      <= '0;
         count        <= '0;
         digit_values <= count_next; // Includes a transfer in the last cycle
      end else begin
         win_cnt <= win_cnt + 1'b1;
         count   <= count_next;
      end
   end

   // The shown value must stay decimal in every digit
   for (genvar g = 0; g < NUM_DIGITS; g++) begin : g_bcd_check
      a_digit_bcd: assert property (@(posedge clk) disable iff (rst)
         digit_values[g] <= 4'd9);
   end

endmodule

`default_nettype wire

/* verilog/segment_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

// Multiplexed drive of a common-anode seven-segment display, one digit per slot
module segment_scanner import display_pkg::*; #(
   parameter int SCAN_CYCLES = 100_000
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [NUM_DIGITS-1:0][3:0] digit_values,
   output seg_code_t                  seg,
   output logic                       dp,
   output logic [NUM_DIGITS-1:0]      an
);

   localparam int SLOT_W = $clog2(SCAN_CYCLES + 1);
   localparam int IDX_W  = $clog2(NUM_DIGITS);

   logic [SLOT_W-1:0] slot_cnt;
   logic [IDX_W-1:0]  idx;        // Digit shown in the next slot
   logic              slot_end;
   logic [3:0]        cur_digit;

   assign slot_end  = (slot_cnt == SLOT_W'(SCAN_CYCLES - 1));
   assign cur_digit = digit_values[idx];

   // All outputs load on the same edge so no digit ghosts onto its neighbour
   always_ff @(posedge clk) begin
      if (rst) begin
         slot_cnt <= '0;
         idx      <= '0;
         seg      <= '1; // Dark until the first slot ends
         dp       <= 1'b1;
         an       <= '1;
      end else if (slot_end) begin
         slot_cnt <= '0;
         idx      <= (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
         // Anything that is not a decimal digit stays blank
         seg <= (cur_digit <= 4'd9) ? DIGIT_SEGMENTS[cur_digit] : '1;
         dp  <= (idx != IDX_W'(DP_DIGIT));
         an  <= ~(NUM_DIGITS'(1) << idx);
      end else begin
         slot_cnt <= slot_cnt + 1'b1;
      end
   end

   // Never two digits lit at once
   a_one_anode: assert property (@(posedge clk) disable iff (rst) $onehot0(~an));

endmodule

`default_nettype wire

/* verilog/board_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Board demo of a UART byte link with a transfer rate display
module board_top import link_pkg::*, display_pkg::*; #(
   parameter int FREQ          = 100_000_000,
   parameter int BAUD          = 3_000_000,
   parameter int WINDOW_CYCLES = FREQ,        // One second of measurement
   parameter int SCAN_CYCLES   = FREQ / 1000  // 1 ms per digit
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  uart_rx,
   output logic                  uart_tx,
   input  logic                  uart_cts,
   output logic                  uart_rts,
   input  logic [2:0]            switch,
   output seg_code_t             seg,
   output logic                  dp,
   output logic [NUM_DIGITS-1:0] an,
   output logic                  redled
);

   localparam int CLKS_PER_BIT = FREQ / BAUD;

   logic [DATA_WIDTH-1:0]      in_data;
   logic                       in_valid;
   logic                       in_ready;
   logic [DATA_WIDTH-1:0]      out_data;
   logic                       out_valid;
   logic                       out_ready;
   logic                       rx_error;
   logic                       xfer_pulse;
   logic [NUM_DIGITS-1:0][3:0] digit_values;

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
      .clk   (clk),
      .rst   (rst),
      .rx    (uart_rx),
      .data  (in_data),
      .valid (in_valid),
      .ready (in_ready),
      .error (rx_error)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
      .clk   (clk),
      .rst   (rst),
      .data  (out_data),
      .valid (out_valid),
      .cts   (uart_cts),
      .ready (out_ready),
      .tx    (uart_tx)
   );

   demo_control u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .switch     (switch),
      .in_data    (in_data),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .rx_error   (rx_error),
      .rts        (uart_rts),
      .xfer_pulse (xfer_pulse),
      .redled     (redled)
   );

   rate_meter #(.WINDOW_CYCLES(WINDOW_CYCLES)) u_meter (
      .clk          (clk),
      .rst          (rst),
      .xfer_pulse   (xfer_pulse),
      .digit_values (digit_values)
   );

   segment_scanner #(.SCAN_CYCLES(SCAN_CYCLES)) u_scan (
      .clk          (clk),
      .rst          (rst),
      .digit_values (digit_values),
      .seg          (seg),
      .dp           (dp),
      .an           (an)
   );

endmodule

`default_nettype wire

/* bench/tb_board_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the UART link demo that drives the serial lines and reads the display
module tb_board_top import link_pkg::*, display_pkg::*; ();

   localparam int CLKS_PER_BIT = 10;                // 1 MHz clock over 100 kbaud
   localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT; // Start, eight data bits, stop
   localparam int WINDOW       = 4000;

   logic                  clk;
   logic                  rst;
   logic                  uart_rx;
   logic                  uart_tx;
   logic                  uart_cts;
   logic                  uart_rts;
   logic [2:0]            switch;
   seg_code_t             seg;
   logic                  dp;
   logic [NUM_DIGITS-1:0] an;
   logic                  redled;

   integer                     seed = 32340;
   int                         cycle_count;  // Clock edges since reset release
   logic [NUM_DIGITS-1:0][3:0] shown_value;  // Digits decoded from the last display scan
   logic [NUM_DIGITS-1:0]      shown_dp;     // dp level seen in each digit slot

   board_top #(
      .FREQ          (1_000_000),
      .BAUD          (100_000),
      .WINDOW_CYCLES (WINDOW),
      .SCAN_CYCLES   (8)
   ) u_dut (
      .clk      (clk),
      .rst      (rst),
      .uart_rx  (uart_rx),
      .uart_tx  (uart_tx),
      .uart_cts (uart_cts),
      .uart_rts (uart_rts),
      .switch   (switch),
      .seg      (seg),
      .dp       (dp),
      .an       (an),
      .redled   (redled)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   // Counts clocks from reset release as the rate meter window does
   always @(posedge clk) begin
      if (rst) cycle_count <= 0;
      else cycle_count <= cycle_count + 1;
   end

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic timeout_fail(input string what);
      $display("Timed out at %0t waiting for %s", $time, what);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   // Inputs change and outputs are sampled 2 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic apply_reset();
      next_cycle();
      rst = 1'b1;
      wait_cycles(3);
      rst = 1'b0;
      check_value("uart_tx", uart_tx, 1); // Values still from the reset itself
      check_value("uart_rts", uart_rts, 0);
      check_value("redled", redled, 0);
      check_value("an", an, {NUM_DIGITS{1'b1}});
   endtask

   // Sends one 8N1 frame where a low stop_level gives a framing error
   task automatic send_byte(input logic [7:0] value, input logic stop_level);
      int i;
      uart_rx = 1'b0;
      wait_cycles(CLKS_PER_BIT);
      for (i = 0; i < 8; i++) begin
         uart_rx = value[i]; // LSB first
         wait_cycles(CLKS_PER_BIT);
      end
      uart_rx = stop_level;
      wait_cycles(CLKS_PER_BIT);
      uart_rx = 1'b1;
      wait_cycles(2); // Short idle gap between frames
   endtask

   task automatic recv_byte(output logic [7:0] value, input int limit, input string what);
      int i;
      bit found;
      found = 1'b0;
      for (i = 0; i < limit && !found; i++) begin
         next_cycle();
         if (uart_tx == 1'b0) found = 1'b1;
      end
      if (!found) timeout_fail(what);
      wait_cycles(CLKS_PER_BIT / 2); // Middle of the start bit
      check_value("uart_tx start bit", uart_tx, 0);
      for (i = 0; i < 8; i++) begin
         wait_cycles(CLKS_PER_BIT);
         value[i] = uart_tx;
      end
      wait_cycles(CLKS_PER_BIT);
      check_value("uart_tx stop bit", uart_tx, 1);
   endtask

   task automatic tx_stays_idle(input int cycles);
      repeat (cycles) begin
         next_cycle();
         check_value("uart_tx", uart_tx, 1);
      end
   endtask

   task automatic redled_toggles(input int cycles);
      logic prev;
      prev = redled;
      repeat (cycles) begin
         next_cycle();
         check_value("redled", redled, !prev);
         prev = redled;
      end
   endtask

   task automatic wait_cycle_count(input int target, input string what);
      int i;
      bit done;
      done = 1'b0;
      for (i = 0; i < 2 * WINDOW && !done; i++) begin
         next_cycle();
         if (cycle_count >= target) done = 1'b1;
      end
      if (!done) timeout_fail(what);
   endtask

   // Unknown patterns come back as f so they never match a decimal digit
   function automatic logic [3:0] decode_segments(input seg_code_t code);
      logic [3:0] digit;
      digit = 4'hf;
      for (int k = 0; k < 10; k++) begin
         if (DIGIT_SEGMENTS[k] == code) digit = k[3:0];
      end
      return digit;
   endfunction

   task automatic read_display();
      int                    d;
      int                    i;
      bit                    found;
      logic [NUM_DIGITS-1:0] want_an;
      for (d = 0; d < NUM_DIGITS; d++) begin
         want_an    = '1;   // Scan visits the digits in order
         want_an[d] = 1'b0; // Only the anode of digit d is driven low
         found      = 1'b0;
         for (i = 0; i < 100 && !found; i++) begin
            next_cycle();
            if (an == want_an) found = 1'b1;
         end
         if (!found) timeout_fail("display digit slot");
         shown_value[d] = decode_segments(seg);
         shown_dp[d]    = dp;
      end
   endtask

   task automatic loopback_echo();
      logic [7:0] sent [0:4];
      logic [7:0] got;
      int         i;
      int         j;
      switch   = 3'b000;
      uart_cts = 1'b1;
      apply_reset();
      for (i = 0; i < 5; i++) sent[i] = $random(seed);
      fork
         for (i = 0; i < 5; i++) send_byte(sent[i], 1'b1);
         for (j = 0; j < 5; j++) begin
            recv_byte(got, 4 * FRAME_CYCLES, "echoed byte");
            check_value("loopback byte", got, sent[j]); // Order must be kept
         end
      join
      check_value("redled", redled, 0);
   endtask

   task automatic pattern_frames();
      logic [7:0] got;
      switch   = 3'b001;
      uart_cts = 1'b1;
      apply_reset();
      repeat (3) begin
         recv_byte(got, 3 * FRAME_CYCLES, "pattern frame");
         check_value("pattern byte", got, PATTERN_BYTE);
      end
      check_value("uart_rts", uart_rts, 0);
   endtask

   task automatic cts_back_pressure();
      logic [7:0] value;
      logic [7:0] got;
      switch   = 3'b000;
      uart_cts = 1'b0; // Far side not ready
      apply_reset();
      value = $random(seed);
      fork
         send_byte(value, 1'b1);
         tx_stays_idle(FRAME_CYCLES);
      join
      tx_stays_idle(2 * FRAME_CYCLES);
      uart_cts = 1'b1;
      recv_byte(got, FRAME_CYCLES, "byte released by cts");
      check_value("flow control byte", got, value);
   endtask

   task automatic sink_overrun();
      switch   = 3'b110; // Sink with switch 2 high
      uart_cts = 1'b1;
      apply_reset();
      wait_cycles(2);
      check_value("uart_rts", uart_rts, 1);
      fork
         begin
            send_byte($random(seed), 1'b1);
            send_byte($random(seed), 1'b1);
         end
         tx_stays_idle(2 * FRAME_CYCLES + 10);
      join
      check_value("redled", redled, 0);
      switch = 3'b010; // Sink closed
      wait_cycles(2);
      check_value("uart_rts", uart_rts, 0);
      send_byte($random(seed), 1'b1);   // Fills the holding register
      send_byte($random(seed), 1'b1);   // Overruns it
      wait_cycles(10);
      redled_toggles(6);
      apply_reset();
      repeat (5) begin
         next_cycle();
         check_value("redled", redled, 0);
      end
   endtask

   task automatic rate_display();
      switch   = 3'b110;
      uart_cts = 1'b1;
      apply_reset();
      repeat (12) send_byte($random(seed), 1'b1); // Well inside the first window
      wait_cycle_count(WINDOW + 2, "end of first window");
      read_display();
      check_value("display digits", shown_value, 32'h0000_0012);
      check_value("dp", shown_dp, 8'hf7); // Only digit 3 lit
      wait_cycle_count(2 * WINDOW + 2, "end of second window");
      read_display();
      check_value("display digits", shown_value, 32'h0000_0000);
      check_value("dp", shown_dp, 8'hf7);
   endtask

   task automatic framing_error();
      switch   = 3'b000;
      uart_cts = 1'b1;
      apply_reset();
      fork
         send_byte($random(seed), 1'b0); // Stop bit held low
         tx_stays_idle(2 * FRAME_CYCLES + 50);
      join
      redled_toggles(6);
   endtask

   initial begin
      rst      = 1'b1;
      uart_rx  = 1'b1; // Line idle
      uart_cts = 1'b1;
      switch   = 3'b000;
      loopback_echo();
      pattern_frames();
      cts_back_pressure();
      sink_overrun();
      rate_display();
      framing_error();
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
verilog/link_pkg.sv
verilog/display_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/demo_control.sv
verilog/rate_meter.sv
verilog/segment_scanner.sv
verilog/board_top.sv
bench/tb_board_top.sv
